// ==== files.f ====
rtl/riscv_pkg.sv
rtl/riscv_decode.sv
rtl/riscv_regfile.sv
rtl/riscv_exu.sv
rtl/riscv_result.sv
rtl/riscv_core.sv
bench/riscv_core_assert.sv
bench/riscv_core_tb.sv

// ==== bench/riscv_core_tb.sv ====
`timescale 1ns/1ps

module riscv_core_tb;

  localparam int          CLK_PERIOD   = 40;
  localparam int          RESET_CYCLES = 10;
  localparam logic [6:0]  ALT          = 7'h20; // funct7 for SUB and SRA

  logic        clk;
  logic        arst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        illegal;

  logic [31:0] tbl_instr [$];
  logic        exp_valid [$];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_pc [$];
  logic        exp_ill [$];
  logic [31:0] model_regs [0:31];
  logic [31:0] model_pc;
  int          errors;
  bit          table_ready;

  riscv_core riscv_core_inst (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    riscv_pkg::instr_u w;
    w.r = {f7, rs2, rs1, f3, rd, riscv_pkg::OPC_OP};
    return w;
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    riscv_pkg::instr_u w;
    w.i = {imm, rs1, f3, rd, opc};
    return w;
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    riscv_pkg::instr_u w;
    w.b = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], riscv_pkg::OPC_BRANCH};
    return w;
  endfunction

  function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                         input logic [19:0] imm);
    riscv_pkg::instr_u w;
    w.u = {imm, rd, opc};
    return w;
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
    riscv_pkg::instr_u w;
    w.j = {off[20], off[10:1], off[11], off[19:12], rd, riscv_pkg::OPC_JAL};
    return w;
  endfunction

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_cond(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Reference model of one instruction, pushes the expected outputs
  function automatic void predict(input logic [31:0] word);
    riscv_pkg::instr_u w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] res;
    logic [31:0] nxt;
    logic        wr;
    logic        ill;
    w     = word;
    a     = model_regs[w.r.rs1];
    b     = model_regs[w.r.rs2];
    imm_i = {{20{word[31]}}, word[31:20]};
    imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    res   = '0;
    nxt   = model_pc + 32'd4;
    wr    = 1'b1;
    ill   = 1'b0;
    case (w.r.opcode)
      riscv_pkg::OPC_OP:     res = alu_model(w.r.funct3, word[30], a, b);
      riscv_pkg::OPC_OP_IMM: res = alu_model(w.i.funct3, word[30] && w.i.funct3 == 3'd5,
                                             a, imm_i);
      riscv_pkg::OPC_LUI:    res = {word[31:12], 12'h000};
      riscv_pkg::OPC_AUIPC:  res = model_pc + {word[31:12], 12'h000};
      riscv_pkg::OPC_JAL: begin
        res = model_pc + 32'd4;
        nxt = model_pc + imm_j;
      end
      riscv_pkg::OPC_JALR: begin
        res = model_pc + 32'd4;
        nxt = (a + imm_i) & ~32'd1;
      end
      riscv_pkg::OPC_BRANCH: begin
        wr = 1'b0;
        if (branch_cond(w.b.funct3, a, b)) begin
          nxt = model_pc + imm_b;
        end
      end
      default: begin
        wr  = 1'b0;
        ill = 1'b1;
      end
    endcase
    exp_valid.push_back(wr && w.r.rd != 5'd0);
    exp_rd.push_back(w.r.rd);
    exp_data.push_back(res);
    exp_pc.push_back(nxt);
    exp_ill.push_back(ill);
    if (wr && w.r.rd != 5'd0) begin
      model_regs[w.r.rd] = res;
    end
    model_pc = nxt;
  endfunction

  task automatic build_table();
    tbl_instr.push_back(i_type(riscv_pkg::OPC_OP_IMM, 3'd0, 5'd1, 5'd0, 12'h123));
    tbl_instr.push_back(i_type(riscv_pkg::OPC_OP_IMM, 3'd0, 5'd2, 5'd0, 12'hFFB)); // -5
    tbl_instr.push_back(u_type(riscv_pkg::OPC_LUI, 5'd3, 20'h80000));
    tbl_instr.push_back(u_type(riscv_pkg::OPC_AUIPC, 5'd4, 20'h00001));
    tbl_instr.push_back(r_type(7'h00, 3'd0, 5'd5, 5'd1, 5'd2));
    tbl_instr.push_back(r_type(ALT, 3'd0, 5'd6, 5'd1, 5'd2));
    tbl_instr.push_back(r_type(7'h00, 3'd1, 5'd7, 5'd1, 5'd2));
    tbl_instr.push_back(r_type(7'h00, 3'd2, 5'd8, 5'd2, 5'd1));
    tbl_instr.push_back(r_type(7'h00, 3'd3, 5'd9, 5'd2, 5'd1));
    tbl_instr.push_back(r_type(7'h00, 3'd2, 5'd30, 5'd1, 5'd3)); // Difference overflows
    tbl_instr.push_back(r_type(7'h00, 3'd4, 5'd10, 5'd1, 5'd2));
    tbl_instr.push_back(r_type(7'h00, 3'd5, 5'd11, 5'd3, 5'd1));
    tbl_instr.push_back(r_type(ALT, 3'd5, 5'd12, 5'd3, 5'd1));
    tbl_instr.push_back(r_type(7'h00, 3'd6, 5'd13, 5'd1, 5'd2));
    tbl_instr.push_back(r_type(7'h00, 3'd7, 5'd14, 5'd1, 5'd2));
    tbl_instr.push_back(i_type(riscv_pkg::OPC_OP_IMM, 3'd2, 5'd15, 5'd2, 12'hFFC));
    tbl_instr.push_back(i_type(riscv_pkg::OPC_OP_IMM, 3'd3, 5'd16, 5'd1, 12'hFFF));
    tbl_instr.push_back(i_type(riscv_pkg::OPC_OP_IMM, 3'd4, 5'd17, 5'd1, 12'h0F0));
    tbl_instr.push_back(i_type(riscv_pkg::OPC_OP_IMM, 3'd6, 5'd18, 5'd2, 12'h700));
    tbl_instr.push_back(i_type(riscv_pkg::OPC_OP_IMM, 3'd7, 5'd19, 5'd2, 12'h8F0));
    tbl_instr.push_back(i_type(riscv_pkg::OPC_OP_IMM, 3'd1, 5'd20, 5'd1, 12'h004));
    tbl_instr.push_back(i_type(riscv_pkg::OPC_OP_IMM, 3'd5, 5'd21, 5'd3, 12'h008));
    tbl_instr.push_back(i_type(riscv_pkg::OPC_OP_IMM, 3'd5, 5'd22, 5'd3, 12'h408)); // SRAI
    tbl_instr.push_back(b_type(3'd0, 5'd1, 5'd1, 13'h0008)); // Taken, then not taken
    tbl_instr.push_back(b_type(3'd0, 5'd1, 5'd2, 13'h0008));
    tbl_instr.push_back(b_type(3'd1, 5'd1, 5'd2, 13'h1FF0)); // Backward
    tbl_instr.push_back(b_type(3'd1, 5'd1, 5'd1, 13'h0008));
    tbl_instr.push_back(b_type(3'd4, 5'd2, 5'd1, 13'h000C));
    tbl_instr.push_back(b_type(3'd4, 5'd1, 5'd2, 13'h000C));
    tbl_instr.push_back(b_type(3'd4, 5'd3, 5'd1, 13'h0008)); // Difference overflows
    tbl_instr.push_back(b_type(3'd5, 5'd1, 5'd2, 13'h0010));
    tbl_instr.push_back(b_type(3'd5, 5'd2, 5'd1, 13'h0010));
    tbl_instr.push_back(b_type(3'd6, 5'd1, 5'd2, 13'h0014));
    tbl_instr.push_back(b_type(3'd6, 5'd2, 5'd1, 13'h0014));
    tbl_instr.push_back(b_type(3'd7, 5'd2, 5'd1, 13'h1FF8));
    tbl_instr.push_back(b_type(3'd7, 5'd1, 5'd2, 13'h0008));
    tbl_instr.push_back(j_type(5'd23, 21'h000100));
    tbl_instr.push_back(u_type(riscv_pkg::OPC_AUIPC, 5'd29, 20'h00000));
    tbl_instr.push_back(i_type(riscv_pkg::OPC_JALR, 3'd0, 5'd24, 5'd1, 12'h012)); // Odd sum
    tbl_instr.push_back(i_type(riscv_pkg::OPC_OP_IMM, 3'd0, 5'd0, 5'd1, 12'h005));
    tbl_instr.push_back(r_type(7'h00, 3'd0, 5'd25, 5'd0, 5'd1));
    tbl_instr.push_back(i_type(7'b1110011, 3'd0, 5'd31, 5'd0, 12'h000)); // SYSTEM is unsupported
    tbl_instr.push_back(i_type(riscv_pkg::OPC_OP_IMM, 3'd0, 5'd26, 5'd0, 12'h007));
    tbl_instr.push_back(i_type(riscv_pkg::OPC_OP_IMM, 3'd0, 5'd26, 5'd26, 12'h001));
    tbl_instr.push_back(r_type(7'h00, 3'd0, 5'd27, 5'd26, 5'd26));
    tbl_instr.push_back(r_type(ALT, 3'd0, 5'd28, 5'd27, 5'd26));
  endtask

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else begin
      errors++;
      $display("FAILED %s got %h expected %h", what, got, want);
    end
  endtask

  task automatic check_outputs(input int i);
    compare($sformatf("entry %0d wb_valid", i), wb_valid, exp_valid[i]);
    compare($sformatf("entry %0d illegal", i), illegal, exp_ill[i]);
    compare($sformatf("entry %0d pc", i), pc, exp_pc[i]);
    if (exp_valid[i]) begin
      compare($sformatf("entry %0d wb_rd", i), wb_rd, exp_rd[i]);
      compare($sformatf("entry %0d wb_data", i), wb_data, exp_data[i]);
    end
  endtask

  initial begin
    int n;
    int i;
    clk         = 1'b0;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    errors      = 0;
    table_ready = 1'b0;
    foreach (model_regs[k]) begin
      model_regs[k] = '0;
    end
    model_pc = riscv_pkg::RESET_PC;
    build_table();
    foreach (tbl_instr[k]) begin
      predict(tbl_instr[k]);
    end
    n           = tbl_instr.size();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    compare("reset pc", pc, riscv_pkg::RESET_PC);
    compare("reset wb_valid", wb_valid, 1'b0);
    compare("reset illegal", illegal, 1'b0);
    for (i = 0; i < n; i++) begin
      @(posedge clk);
      instr_valid <= 1'b1;
      instr       <= tbl_instr[i];
      if (i > 0) begin
        @(negedge clk);
        check_outputs(i - 1); // Previous entry is now on the outputs
      end
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    @(negedge clk);
    check_outputs(n - 1);
    repeat (2) @(negedge clk);
    compare("idle pc", pc, exp_pc[n - 1]); // No strobe, pc holds
    compare("idle wb_valid", wb_valid, 1'b0);
    $display("Check errors: %0d, assertion errors: %0d", errors,
             riscv_core_inst.riscv_core_assert_inst.fail_count);
    if (errors == 0 && riscv_core_inst.riscv_core_assert_inst.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    wait (table_ready);
    #((RESET_CYCLES + tbl_instr.size() + 20) * CLK_PERIOD);
    $display("Timeout: the instruction table did not finish in the expected time");
    $display("Check errors: %0d, assertion errors: %0d", errors,
             riscv_core_inst.riscv_core_assert_inst.fail_count);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== bench/riscv_core_assert.sv ====
`timescale 1ns/1ps

module riscv_core_assert (
  input logic                       clk,
  input logic                       arst_n,
  input logic [riscv_pkg::XLEN-1:0] pc,
  input logic                       wb_valid,
  input logic [4:0]                 wb_rd,
  input logic                       illegal
);

  int fail_count = 0;

  assert property (@(posedge clk) disable iff (!arst_n) wb_valid |-> wb_rd != 5'd0)
    else begin
      $error("wb_valid high with wb_rd equal to x0");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
    else begin
      $error("pc is not word aligned");
      fail_count++;
    end

  // Illegal instructions never write back
  assert property (@(posedge clk) disable iff (!arst_n) !(wb_valid && illegal))
    else begin
      $error("wb_valid and illegal high in the same cycle");
      fail_count++;
    end

endmodule

bind riscv_core riscv_core_assert riscv_core_assert_inst (
  .clk      (clk),
  .arst_n   (arst_n),
  .pc       (pc),
  .wb_valid (wb_valid),
  .wb_rd    (wb_rd),
  .illegal  (illegal)
);

// ==== rtl/riscv_core.sv ====
`timescale 1ns/1ps

module riscv_core (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       instr_valid,
  input  logic [riscv_pkg::XLEN-1:0] instr,
  output logic [riscv_pkg::XLEN-1:0] pc,
  output logic                       wb_valid,
  output logic [4:0]                 wb_rd,
  output logic [riscv_pkg::XLEN-1:0] wb_data,
  output logic                       illegal
);

  logic [4:0]                      rs1_addr;
  logic [4:0]                      rs2_addr;
  logic [4:0]                      rd;
  logic [riscv_pkg::XLEN-1:0]      imm;
  logic [riscv_pkg::ALU_OP_W-1:0]  alu_op;
  logic [riscv_pkg::SRC_SEL_W-1:0] src_sel;
  logic [2:0]                      funct3;
  logic                            branch;
  logic                            jump;
  logic                            jalr;
  logic                            reg_write;
  logic                            illegal_instr;
  logic [riscv_pkg::XLEN-1:0]      rs1_data;
  logic [riscv_pkg::XLEN-1:0]      rs2_data;
  logic [riscv_pkg::XLEN-1:0]      exu_result;
  logic [riscv_pkg::XLEN-1:0]      target;
  logic                            we;
  logic [4:0]                      waddr;
  logic [riscv_pkg::XLEN-1:0]      wdata;

  riscv_decode riscv_decode_inst (
    .instr         (instr),
    .rs1_addr      (rs1_addr),
    .rs2_addr      (rs2_addr),
    .rd            (rd),
    .imm           (imm),
    .alu_op        (alu_op),
    .src_sel       (src_sel),
    .funct3        (funct3),
    .branch        (branch),
    .jump          (jump),
    .jalr          (jalr),
    .reg_write     (reg_write),
    .illegal_instr (illegal_instr)
  );

  riscv_regfile riscv_regfile_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (we),
    .waddr    (waddr),
    .wdata    (wdata)
  );

  riscv_exu riscv_exu_inst (
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .alu_op     (alu_op),
    .src_sel    (src_sel),
    .funct3     (funct3),
    .branch     (branch),
    .jalr       (jalr),
    .exu_result (exu_result),
    .target     (target)
  );

  riscv_result riscv_result_inst (
    .clk           (clk),
    .arst_n        (arst_n),
    .instr_valid   (instr_valid),
    .exu_result    (exu_result),
    .target        (target),
    .rd            (rd),
    .reg_write     (reg_write),
    .branch        (branch),
    .jump          (jump),
    .illegal_instr (illegal_instr),
    .we            (we),
    .waddr         (waddr),
    .wdata         (wdata),
    .pc            (pc),
    .wb_valid      (wb_valid),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .illegal       (illegal)
  );

endmodule

// ==== rtl/riscv_result.sv ====
`timescale 1ns/1ps

module riscv_result (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       instr_valid,
  input  logic [riscv_pkg::XLEN-1:0] exu_result,
  input  logic [riscv_pkg::XLEN-1:0] target,
  input  logic [4:0]                 rd,
  input  logic                       reg_write,
  input  logic                       branch,
  input  logic                       jump,
  input  logic                       illegal_instr,
  output logic                       we,
  output logic [4:0]                 waddr,
  output logic [riscv_pkg::XLEN-1:0] wdata,
  output logic [riscv_pkg::XLEN-1:0] pc,
  output logic                       wb_valid,
  output logic [4:0]                 wb_rd,
  output logic [riscv_pkg::XLEN-1:0] wb_data,
  output logic                       illegal
);

  logic [riscv_pkg::XLEN-1:0] next_pc;
  logic                       taken;

  assign taken   = jump | (branch & exu_result[0]);
  assign next_pc = taken ? target : pc + 32'd4;

  assign we    = instr_valid & reg_write & (rd != 5'd0);
  assign waddr = rd;
  assign wdata = exu_result;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc       <= riscv_pkg::RESET_PC;
      wb_valid <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      wb_valid <= we;
      illegal  <= instr_valid & illegal_instr;
      if (instr_valid) begin
        pc <= next_pc; // Holds between strobes
      end
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      wb_rd   <= rd;
      wb_data <= exu_result;
    end
  end

endmodule

// ==== rtl/riscv_exu.sv ====
`timescale 1ns/1ps

module riscv_exu (
  input  logic [riscv_pkg::XLEN-1:0]      pc,
  input  logic [riscv_pkg::XLEN-1:0]      rs1_data,
  input  logic [riscv_pkg::XLEN-1:0]      rs2_data,
  input  logic [riscv_pkg::XLEN-1:0]      imm,
  input  logic [riscv_pkg::ALU_OP_W-1:0]  alu_op,
  input  logic [riscv_pkg::SRC_SEL_W-1:0] src_sel,
  input  logic [2:0]                      funct3,
  input  logic                            branch,
  input  logic                            jalr,
  output logic [riscv_pkg::XLEN-1:0]      exu_result,
  output logic [riscv_pkg::XLEN-1:0]      target
);

  logic [riscv_pkg::XLEN-1:0] alu_a;
  logic [riscv_pkg::XLEN-1:0] alu_b;
  logic [riscv_pkg::XLEN-1:0] alu_out;
  logic [riscv_pkg::XLEN-1:0] diff;
  logic [riscv_pkg::XLEN-1:0] jump_sum;
  logic                       carry;
  logic                       overflow;
  logic                       less;
  logic                       zero;
  logic                       cond;

  always_comb begin
    case (src_sel)
      riscv_pkg::SRC_RS1_RS2: begin
        alu_a = rs1_data;
        alu_b = rs2_data;
      end
      riscv_pkg::SRC_RS1_IMM: begin
        alu_a = rs1_data;
        alu_b = imm;
      end
      riscv_pkg::SRC_PC_4: begin
        alu_a = pc;
        alu_b = 32'd4;
      end
      default: begin
        alu_a = pc;
        alu_b = imm;
      end
    endcase
  end

  assign {carry, diff} = {1'b0, alu_a} - {1'b0, alu_b}; // Top bit is the borrow
  assign overflow = (alu_a[31] ^ alu_b[31]) & (diff[31] ^ alu_a[31]);
  assign less     = diff[31] ^ overflow;

  always_comb begin
    case (alu_op)
      riscv_pkg::ALU_ADD:    alu_out = alu_a + alu_b;
      riscv_pkg::ALU_SUB:    alu_out = diff;
      riscv_pkg::ALU_SLL:    alu_out = alu_a << alu_b[4:0];
      riscv_pkg::ALU_SLT:    alu_out = {{(riscv_pkg::XLEN-1){1'b0}}, less};
      riscv_pkg::ALU_SLTU:   alu_out = {{(riscv_pkg::XLEN-1){1'b0}}, carry};
      riscv_pkg::ALU_XOR:    alu_out = alu_a ^ alu_b;
      riscv_pkg::ALU_SRL:    alu_out = alu_a >> alu_b[4:0];
      riscv_pkg::ALU_SRA:    alu_out = $signed(alu_a) >>> alu_b[4:0];
      riscv_pkg::ALU_OR:     alu_out = alu_a | alu_b;
      riscv_pkg::ALU_AND:    alu_out = alu_a & alu_b;
      riscv_pkg::ALU_PASS_B: alu_out = alu_b;
      default:               alu_out = '0;
    endcase
  end

  assign zero = ~(|alu_out);

  always_comb begin
    case (funct3)
      3'b000:  cond = zero;   // BEQ
      3'b001:  cond = ~zero;  // BNE
      3'b100:  cond = less;   // BLT
      3'b101:  cond = ~less;  // BGE
      3'b110:  cond = carry;  // BLTU
      3'b111:  cond = ~carry; // BGEU
      default: cond = 1'b0;
    endcase
  end

  assign exu_result = branch ? {{(riscv_pkg::XLEN-1){1'b0}}, cond} : alu_out;

  assign jump_sum = (jalr ? rs1_data : pc) + imm;
  assign target   = {jump_sum[riscv_pkg::XLEN-1:1], jump_sum[0] & ~jalr};

endmodule

// ==== rtl/riscv_regfile.sv ====
`timescale 1ns/1ps

module riscv_regfile (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic [4:0]                 rs1_addr,
  input  logic [4:0]                 rs2_addr,
  output logic [riscv_pkg::XLEN-1:0] rs1_data,
  output logic [riscv_pkg::XLEN-1:0] rs2_data,
  input  logic                       we,
  input  logic [4:0]                 waddr,
  input  logic [riscv_pkg::XLEN-1:0] wdata
);

  logic [riscv_pkg::XLEN-1:0] regs [1:31]; // No storage for x0

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== rtl/riscv_decode.sv ====
`timescale 1ns/1ps

module riscv_decode (
  input  logic [riscv_pkg::XLEN-1:0]      instr,
  output logic [4:0]                      rs1_addr,
  output logic [4:0]                      rs2_addr,
  output logic [4:0]                      rd,
  output logic [riscv_pkg::XLEN-1:0]      imm,
  output logic [riscv_pkg::ALU_OP_W-1:0]  alu_op,
  output logic [riscv_pkg::SRC_SEL_W-1:0] src_sel,
  output logic [2:0]                      funct3,
  output logic                            branch,
  output logic                            jump,
  output logic                            jalr,
  output logic                            reg_write,
  output logic                            illegal_instr
);

  riscv_pkg::instr_u iw;
  logic              alt;

  // Shared by OP and OP-IMM
  function automatic logic [riscv_pkg::ALU_OP_W-1:0] alu_from_funct3(
    input logic [2:0] f3,
    input logic       alt_op
  );
    logic [riscv_pkg::ALU_OP_W-1:0] op;
    case (f3)
      3'b000:  op = alt_op ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
      3'b001:  op = riscv_pkg::ALU_SLL;
      3'b010:  op = riscv_pkg::ALU_SLT;
      3'b011:  op = riscv_pkg::ALU_SLTU;
      3'b100:  op = riscv_pkg::ALU_XOR;
      3'b101:  op = alt_op ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
      3'b110:  op = riscv_pkg::ALU_OR;
      default: op = riscv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign iw       = instr;
  assign rs1_addr = iw.i.rs1;
  assign rs2_addr = iw.s.rs2;
  assign rd       = iw.r.rd;
  assign funct3   = iw.b.funct3;
  assign alt      = iw.r.funct7[5];

  always_comb begin
    imm           = '0;
    alu_op        = riscv_pkg::ALU_ADD;
    src_sel       = riscv_pkg::SRC_RS1_RS2;
    branch        = 1'b0;
    jump          = 1'b0;
    jalr          = 1'b0;
    reg_write     = 1'b0;
    illegal_instr = 1'b0;
    case (iw.r.opcode)
      riscv_pkg::OPC_OP: begin
        alu_op    = alu_from_funct3(iw.r.funct3, alt);
        reg_write = 1'b1;
      end
      riscv_pkg::OPC_OP_IMM: begin
        imm       = {{20{iw.i.imm_11_0[11]}}, iw.i.imm_11_0};
        alu_op    = alu_from_funct3(iw.i.funct3, alt && iw.i.funct3 == 3'b101); // SRAI only
        src_sel   = riscv_pkg::SRC_RS1_IMM;
        reg_write = 1'b1;
      end
      riscv_pkg::OPC_LUI: begin
        imm       = {iw.u.imm_31_12, 12'b0};
        alu_op    = riscv_pkg::ALU_PASS_B;
        src_sel   = riscv_pkg::SRC_RS1_IMM;
        reg_write = 1'b1;
      end
      riscv_pkg::OPC_AUIPC: begin
        imm       = {iw.u.imm_31_12, 12'b0};
        src_sel   = riscv_pkg::SRC_PC_IMM;
        reg_write = 1'b1;
      end
      riscv_pkg::OPC_JAL: begin
        imm       = {{11{iw.j.imm_20}}, iw.j.imm_20, iw.j.imm_19_12, iw.j.imm_11,
                     iw.j.imm_10_1, 1'b0};
        src_sel   = riscv_pkg::SRC_PC_4;
        jump      = 1'b1;
        reg_write = 1'b1;
      end
      riscv_pkg::OPC_JALR: begin
        imm       = {{20{iw.i.imm_11_0[11]}}, iw.i.imm_11_0};
        src_sel   = riscv_pkg::SRC_PC_4;
        jump      = 1'b1;
        jalr      = 1'b1;
        reg_write = 1'b1;
      end
      riscv_pkg::OPC_BRANCH: begin
        imm    = {{19{iw.b.imm_12}}, iw.b.imm_12, iw.b.imm_11, iw.b.imm_10_5,
                  iw.b.imm_4_1, 1'b0};
        alu_op = riscv_pkg::ALU_SUB; // Condition from difference and borrow
        branch = 1'b1;
      end
      default: illegal_instr = 1'b1;
    endcase
  end

endmodule

// ==== rtl/riscv_pkg.sv ====
package riscv_pkg;

  localparam int XLEN = 32;

  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // Major opcodes, bits 6:0 of the instruction
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  localparam int ALU_OP_W = 4;

  localparam logic [ALU_OP_W-1:0] ALU_ADD    = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB    = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLL    = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT    = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU   = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_XOR    = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL    = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA    = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_OR     = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_AND    = 4'd9;
  localparam logic [ALU_OP_W-1:0] ALU_PASS_B = 4'd10; // LUI

  localparam int SRC_SEL_W = 2;

  localparam logic [SRC_SEL_W-1:0] SRC_RS1_RS2 = 2'd0;
  localparam logic [SRC_SEL_W-1:0] SRC_RS1_IMM = 2'd1;
  localparam logic [SRC_SEL_W-1:0] SRC_PC_4    = 2'd2; // Link address
  localparam logic [SRC_SEL_W-1:0] SRC_PC_IMM  = 2'd3;

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } instr_u;

endpackage
